// File: Makefile
TOP := sata_phy_core_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

obj_dir/V$(TOP): build.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/sata_phy_core_checker.sv
`timescale 1ns/1ps

module sata_phy_core_checker (
    input logic clk,
    input logic extrst,
    input logic cplllock,
    input logic rst,
    input logic gtx_ready,
    input logic rxuserrdy,
    input logic txuserrdy,
    input logic txpcsreset
);

    logic [4:0] pcs_high_cycles;
    logic       pcs_fail   = 1'b0;
    logic       ready_fail = 1'b0;
    logic       rst_fail   = 1'b0;
    logic       assert_failed;

    // consecutive edges with the recalibration pulse high
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            pcs_high_cycles <= '0;
        end else if (!txpcsreset) begin
            pcs_high_cycles <= '0;
        end else if (pcs_high_cycles != 5'd31) begin
            pcs_high_cycles <= pcs_high_cycles + 5'd1;
        end
    end

    pcs_pulse_bounded: assert property (@(posedge clk) disable iff (extrst)
        pcs_high_cycles <= 5'(sata_phy_pkg::TXPCSRESET_CYCLES))
    else begin
        $error("txpcsreset stayed high past the recalibration window");
        pcs_fail = 1'b1;
    end

    ready_needs_userrdy: assert property (@(posedge clk) disable iff (extrst)
        gtx_ready |-> (rxuserrdy && txuserrdy))
    else begin
        $error("gtx_ready high without both user-ready flags");
        ready_fail = 1'b1;
    end

    // internal reset only follows a locked channel pll
    rst_needs_lock: assert property (@(posedge clk) disable iff (extrst)
        !(rst && !cplllock))
    else begin
        $error("rst high while cplllock is low");
        rst_fail = 1'b1;
    end

    assign assert_failed = pcs_fail | ready_fail | rst_fail;

endmodule

bind sata_phy_core sata_phy_core_checker sata_phy_core_checker_i (
    .clk        (clk),
    .extrst     (extrst),
    .cplllock   (cplllock),
    .rst        (rst),
    .gtx_ready  (gtx_ready),
    .rxuserrdy  (rxuserrdy),
    .txuserrdy  (txuserrdy),
    .txpcsreset (txpcsreset)
);

// File: bench/sata_phy_core_tb.sv
`timescale 1ns/1ps

module sata_phy_core_tb;

    localparam int CLK_PERIOD = 20;
    // cycles of reset and of each test in run order
    localparam int TEST_CYCLES = 3 + 37 + 37 + 13 + 10 + 6;
    localparam int RUN_CYCLES  = TEST_CYCLES + 50;

    logic                 clk;
    logic                 extrst;
    logic                 cplllock;
    logic                 usrpll_locked;
    logic                 rxresetdone;
    logic                 txresetdone;
    logic                 txpcsreset_req;
    logic                 link_up;
    sata_phy_pkg::word_t  txdata_oob;
    sata_phy_pkg::flags_t txcharisk_oob;
    sata_phy_pkg::word_t  ll_data_in;
    sata_phy_pkg::flags_t ll_charisk_in;
    sata_phy_pkg::word_t  rxdata_gtx;
    sata_phy_pkg::flags_t rxcharisk_gtx;
    sata_phy_pkg::flags_t rxchariscomma_gtx;
    sata_phy_pkg::flags_t rxdisperr_gtx;
    sata_phy_pkg::flags_t rxnotintable_gtx;
    logic                 rst;
    logic                 gtx_ready;
    logic                 gtxreset;
    logic                 rxuserrdy;
    logic                 txuserrdy;
    logic                 txpcsreset;
    logic                 recal_tx_done;
    sata_phy_pkg::word_t  txdata;
    sata_phy_pkg::flags_t txcharisk;
    sata_phy_pkg::word_t  ll_data_out;
    sata_phy_pkg::flags_t ll_charisk_out;
    sata_phy_pkg::flags_t ll_err_out;

    int   seed = 9412;
    int   test_errors = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    // expected aligner state from the comma rule
    logic model_shift = 1'b0;

    sata_phy_core sata_phy_core_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error %s: %s expected %h actual %h", test, what, expected, actual);
        test_errors++;
    endtask

    task automatic close_test(input string test);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", test);
        end else begin
            $display("%s: failed with %0d errors", test, test_errors);
            tests_failed++;
            errors += test_errors;
        end
        test_errors = 0;
    endtask

    function automatic sata_phy_pkg::word_t rand_word();
        sata_phy_pkg::word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic sata_phy_pkg::flags_t rand_flags();
        logic [31:0] r;
        r = $random(seed);
        return r[3:0];
    endfunction

    // a shifted output byte i comes from raw byte i+2
    function automatic sata_phy_pkg::word_t expect_data(input sata_phy_pkg::word_t w,
                                                        input logic shift);
        sata_phy_pkg::word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = shift ? w[8*((i + 2) % 4) +: 8] : w[8*i +: 8];
        end
        return r;
    endfunction

    function automatic sata_phy_pkg::flags_t expect_flags(input sata_phy_pkg::flags_t f,
                                                          input logic shift);
        sata_phy_pkg::flags_t r;
        for (int i = 0; i < 4; i++) begin
            r[i] = shift ? f[(i + 2) % 4] : f[i];
        end
        return r;
    endfunction

    // one rx word in and its registered result checked after the edge
    task automatic send_rx_word(input string test, input sata_phy_pkg::word_t data,
                                input sata_phy_pkg::flags_t k, input sata_phy_pkg::flags_t comma,
                                input sata_phy_pkg::flags_t disp, input sata_phy_pkg::flags_t nit);
        sata_phy_pkg::word_t  exp_data;
        sata_phy_pkg::flags_t exp_k;
        sata_phy_pkg::flags_t exp_err;
        rxdata_gtx        = data;
        rxcharisk_gtx     = k;
        rxchariscomma_gtx = comma;
        rxdisperr_gtx     = disp;
        rxnotintable_gtx  = nit;
        exp_data = expect_data(data, model_shift);
        exp_k    = expect_flags(k, model_shift);
        exp_err  = expect_flags(disp | nit, model_shift);
        // byte 2 comma wins over byte 0
        if (comma[2]) begin
            model_shift = 1'b1;
        end else if (comma[0]) begin
            model_shift = 1'b0;
        end
        next_cycle();
        if (ll_data_out !== exp_data)
            report_mismatch(test, "ll_data_out", exp_data, ll_data_out);
        if (ll_charisk_out !== exp_k)
            report_mismatch(test, "ll_charisk_out", 32'(exp_k), 32'(ll_charisk_out));
        if (ll_err_out !== exp_err)
            report_mismatch(test, "ll_err_out", 32'(exp_err), 32'(ll_err_out));
    endtask

    task automatic test_reset_sequencing();
        string name = "reset_sequencing";
        logic  exp_tx;
        logic  exp_rx;
        cplllock      = 1'b1;
        usrpll_locked = 1'b1;
        #1;
        if (gtxreset !== 1'b0)
            report_mismatch(name, "gtxreset", 32'd0, 32'(gtxreset));
        if (txuserrdy !== 1'b0)
            report_mismatch(name, "txuserrdy", 32'd0, 32'(txuserrdy));
        for (int n = 1; n <= int'(sata_phy_pkg::RXEYERESET_TIME); n++) begin
            next_cycle();
            exp_tx = (n >= int'(sata_phy_pkg::TXPMARESET_TIME));
            exp_rx = (n >= int'(sata_phy_pkg::RXEYERESET_TIME));
            if (txuserrdy !== exp_tx)
                report_mismatch(name, "txuserrdy", 32'(exp_tx), 32'(txuserrdy));
            if (rxuserrdy !== exp_rx)
                report_mismatch(name, "rxuserrdy", 32'(exp_rx), 32'(rxuserrdy));
            // reset-done inputs are still low
            if (gtx_ready !== 1'b0)
                report_mismatch(name, "gtx_ready", 32'd0, 32'(gtx_ready));
        end
        rxresetdone = 1'b1;
        #1;
        if (gtx_ready !== 1'b0)
            report_mismatch(name, "gtx_ready with rx done only", 32'd0, 32'(gtx_ready));
        next_cycle();
        txresetdone = 1'b1;
        #1;
        if (gtx_ready !== 1'b1)
            report_mismatch(name, "gtx_ready", 32'd1, 32'(gtx_ready));
        next_cycle();
        close_test(name);
    endtask

    task automatic test_rst_pulse();
        string name = "rst_pulse";
        logic  exp_rst;
        if (rst !== 1'b0)
            report_mismatch(name, "rst before relock", 32'd0, 32'(rst));
        cplllock = 1'b0;
        #1;
        if (gtxreset !== 1'b1)
            report_mismatch(name, "gtxreset without lock", 32'd1, 32'(gtxreset));
        next_cycle();
        next_cycle();
        if (rst !== 1'b0)
            report_mismatch(name, "rst without lock", 32'd0, 32'(rst));
        if (gtx_ready !== 1'b0)
            report_mismatch(name, "gtx_ready without lock", 32'd0, 32'(gtx_ready));
        cplllock = 1'b1;
        for (int n = 1; n <= int'(sata_phy_pkg::RXEYERESET_TIME); n++) begin
            next_cycle();
            // high from the second edge for limit-1 cycles
            exp_rst = (n >= 2) && (n <= int'(sata_phy_pkg::RST_TIMER_LIMIT));
            if (rst !== exp_rst)
                report_mismatch(name, "rst", 32'(exp_rst), 32'(rst));
        end
        if (gtx_ready !== 1'b1)
            report_mismatch(name, "gtx_ready after relock", 32'd1, 32'(gtx_ready));
        close_test(name);
    endtask

    task automatic test_tx_recal();
        string name = "tx_recal";
        logic  exp_pcs;
        txpcsreset_req = 1'b1;
        #1;
        if (txpcsreset !== 1'b1)
            report_mismatch(name, "txpcsreset at request", 32'd1, 32'(txpcsreset));
        if (recal_tx_done !== 1'b0)
            report_mismatch(name, "recal_tx_done at request", 32'd0, 32'(recal_tx_done));
        for (int n = 1; n <= int'(sata_phy_pkg::TXPCSRESET_CYCLES) + 2; n++) begin
            next_cycle();
            exp_pcs = (n < int'(sata_phy_pkg::TXPCSRESET_CYCLES));
            if (txpcsreset !== exp_pcs)
                report_mismatch(name, "txpcsreset", 32'(exp_pcs), 32'(txpcsreset));
            // gtx_ready is high here
            if (recal_tx_done !== !exp_pcs)
                report_mismatch(name, "recal_tx_done", 32'(!exp_pcs), 32'(recal_tx_done));
        end
        rxresetdone = 1'b0;
        #1;
        if (recal_tx_done !== 1'b0)
            report_mismatch(name, "recal_tx_done without ready", 32'd0, 32'(recal_tx_done));
        next_cycle();
        rxresetdone = 1'b1;
        #1;
        if (recal_tx_done !== 1'b1)
            report_mismatch(name, "recal_tx_done with ready", 32'd1, 32'(recal_tx_done));
        next_cycle();
        txpcsreset_req = 1'b0;
        next_cycle();
        if (recal_tx_done !== 1'b0)
            report_mismatch(name, "recal_tx_done after request", 32'd0, 32'(recal_tx_done));
        if (txpcsreset !== 1'b0)
            report_mismatch(name, "txpcsreset after request", 32'd0, 32'(txpcsreset));
        close_test(name);
    endtask

    task automatic test_word_align();
        string                name = "word_align";
        sata_phy_pkg::flags_t comma;
        // byte 2 comma on word 0 and byte 0 comma on word 6
        for (int n = 0; n < 10; n++) begin
            comma = 4'b0000;
            if (n == 0)
                comma = 4'b0100;
            if (n == 6)
                comma = 4'b0001;
            send_rx_word(name, rand_word(), rand_flags() | comma, comma, 4'b0000, 4'b0000);
        end
        close_test(name);
    endtask

    task automatic test_tx_select_errors();
        string name = "tx_select_errors";
        link_up       = 1'b0;
        txdata_oob    = rand_word();
        txcharisk_oob = rand_flags();
        ll_data_in    = rand_word();
        ll_charisk_in = rand_flags();
        #1;
        if (txdata !== txdata_oob)
            report_mismatch(name, "txdata from oob", txdata_oob, txdata);
        if (txcharisk !== txcharisk_oob)
            report_mismatch(name, "txcharisk from oob", 32'(txcharisk_oob), 32'(txcharisk));
        next_cycle();
        link_up = 1'b1;
        #1;
        if (txdata !== ll_data_in)
            report_mismatch(name, "txdata from link", ll_data_in, txdata);
        if (txcharisk !== ll_charisk_in)
            report_mismatch(name, "txcharisk from link", 32'(ll_charisk_in), 32'(txcharisk));
        next_cycle();
        // errors on a shifted word and on the word that ends the shift and then on direct ones
        send_rx_word(name, rand_word(), 4'b0100, 4'b0100, 4'b0000, 4'b0000);
        send_rx_word(name, rand_word(), 4'b0000, 4'b0000, 4'b0010, 4'b0001);
        send_rx_word(name, rand_word(), 4'b0001, 4'b0001, 4'b1000, 4'b0000);
        send_rx_word(name, rand_word(), 4'b0000, 4'b0000, 4'b0100, 4'b0010);
        close_test(name);
    endtask

    initial begin
        extrst            = 1'b1;
        cplllock          = 1'b0;
        usrpll_locked     = 1'b0;
        rxresetdone       = 1'b0;
        txresetdone       = 1'b0;
        txpcsreset_req    = 1'b0;
        link_up           = 1'b0;
        txdata_oob        = '0;
        txcharisk_oob     = '0;
        ll_data_in        = '0;
        ll_charisk_in     = '0;
        rxdata_gtx        = '0;
        rxcharisk_gtx     = '0;
        rxchariscomma_gtx = '0;
        rxdisperr_gtx     = '0;
        rxnotintable_gtx  = '0;
        repeat (2) @(posedge clk);
        #2;
        extrst = 1'b0;
        next_cycle();
        test_reset_sequencing();
        test_rst_pulse();
        test_tx_recal();
        test_word_align();
        test_tx_select_errors();
        if (sata_phy_core_i.sata_phy_core_checker_i.assert_failed) begin
            $display("the bound checker saw at least one assertion fail");
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: build.f
src/sata_phy_pkg.sv
src/phy_reset_seq.sv
src/rx_word_align.sv
src/link_port.sv
src/sata_phy_core.sv
bench/sata_phy_core_checker.sv
bench/sata_phy_core_tb.sv

// File: src/link_port.sv
`timescale 1ns/1ps

module link_port (
    input  logic                 clk,
    input  logic                 extrst,
    input  logic                 rst,
    input  logic                 link_up,
    input  sata_phy_pkg::word_t  ll_data_in,
    input  sata_phy_pkg::flags_t ll_charisk_in,
    input  sata_phy_pkg::word_t  txdata_oob,
    input  sata_phy_pkg::flags_t txcharisk_oob,
    input  sata_phy_pkg::word_t  rxdata,
    input  sata_phy_pkg::flags_t rxcharisk,
    input  sata_phy_pkg::flags_t rxdisperr,
    input  sata_phy_pkg::flags_t rxnotintable,
    output sata_phy_pkg::word_t  txdata,
    output sata_phy_pkg::flags_t txcharisk,
    output sata_phy_pkg::word_t  ll_data_out,
    output sata_phy_pkg::flags_t ll_charisk_out,
    output sata_phy_pkg::flags_t ll_err_out
);

    sata_phy_pkg::flags_t rx_err;

    // oob controller owns the lane until the link is up
    assign txdata    = link_up ? ll_data_in    : txdata_oob;
    assign txcharisk = link_up ? ll_charisk_in : txcharisk_oob;

    // per-byte error, bad disparity or invalid code
    assign rx_err = rxdisperr | rxnotintable;

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            ll_data_out    <= '0;
            ll_charisk_out <= '0;
            ll_err_out     <= '0;
        end else if (rst) begin
            ll_data_out    <= '0;
            ll_charisk_out <= '0;
            ll_err_out     <= '0;
        end else begin
            ll_data_out    <= rxdata;
            ll_charisk_out <= rxcharisk;
            ll_err_out     <= rx_err;
        end
    end

endmodule

// File: src/phy_reset_seq.sv
`timescale 1ns/1ps

module phy_reset_seq (
    input  logic clk,
    input  logic extrst,
    input  logic cplllock,
    input  logic usrpll_locked,
    input  logic rxresetdone,
    input  logic txresetdone,
    input  logic txpcsreset_req,
    output logic gtxreset,
    output logic rxuserrdy,
    output logic txuserrdy,
    output logic gtx_ready,
    output logic rst,
    output logic txpcsreset,
    output logic recal_tx_done
);

    logic [2:0] txpmareset_cnt;
    logic [6:0] rxeyereset_cnt;
    logic       txpmareset_done;
    logic       rxeyereset_done;
    logic [7:0] rst_timer;
    logic       rst_r;
    logic [3:0] txpcsreset_cnt;
    logic       txpcsreset_stop;

    // transceiver held in reset until the channel pll locks
    assign gtxreset = extrst | ~cplllock;

    // tx pma window
    assign txpmareset_done = (txpmareset_cnt == sata_phy_pkg::TXPMARESET_TIME);

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            txpmareset_cnt <= '0;
        end else if (gtxreset) begin
            txpmareset_cnt <= '0;
        end else if (!txpmareset_done) begin
            txpmareset_cnt <= txpmareset_cnt + 3'd1;
        end
    end

    // rx eye reset window, sum of all rx sub-resets
    assign rxeyereset_done = (rxeyereset_cnt == sata_phy_pkg::RXEYERESET_TIME);

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rxeyereset_cnt <= '0;
        end else if (gtxreset) begin
            rxeyereset_cnt <= '0;
        end else if (!rxeyereset_done) begin
            rxeyereset_cnt <= rxeyereset_cnt + 7'd1;
        end
    end

    // user clocks must be running as well
    assign txuserrdy = usrpll_locked & ~gtxreset & txpmareset_done;
    assign rxuserrdy = usrpll_locked & ~gtxreset & rxeyereset_done;

    assign gtx_ready = rxuserrdy & txuserrdy & rxresetdone & txresetdone;

    // internal reset timer restarts on any loss of lock
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rst_timer <= '0;
        end else if (!cplllock || !usrpll_locked) begin
            rst_timer <= '0;
        end else if (rst_timer != sata_phy_pkg::RST_TIMER_LIMIT) begin
            rst_timer <= rst_timer + 8'd1;
        end
    end

    // pulse while the timer is strictly between 0 and the limit
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rst_r <= 1'b0;
        end else begin
            rst_r <= (rst_timer != 8'd0) && (rst_timer < sata_phy_pkg::RST_TIMER_LIMIT);
        end
    end

    assign rst = rst_r;

    // bounded tx pcs recalibration
    assign txpcsreset_stop = (txpcsreset_cnt == sata_phy_pkg::TXPCSRESET_CYCLES);

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            txpcsreset_cnt <= '0;
        end else if (rst_r || !txpcsreset_req) begin
            txpcsreset_cnt <= '0;
        end else if (!txpcsreset_stop) begin
            txpcsreset_cnt <= txpcsreset_cnt + 4'd1;
        end
    end

    // request goes straight through until the count runs out
    assign txpcsreset    = txpcsreset_req & ~txpcsreset_stop;
    assign recal_tx_done = txpcsreset_stop & gtx_ready;

endmodule

// File: src/rx_word_align.sv
`timescale 1ns/1ps

module rx_word_align (
    input  logic                 clk,
    input  logic                 extrst,
    input  logic                 rst,
    input  sata_phy_pkg::word_t  rxdata_gtx,
    input  sata_phy_pkg::flags_t rxcharisk_gtx,
    input  sata_phy_pkg::flags_t rxchariscomma_gtx,
    input  sata_phy_pkg::flags_t rxdisperr_gtx,
    input  sata_phy_pkg::flags_t rxnotintable_gtx,
    output sata_phy_pkg::word_t  rxdata,
    output sata_phy_pkg::flags_t rxcharisk,
    output sata_phy_pkg::flags_t rxdisperr,
    output sata_phy_pkg::flags_t rxnotintable
);

    localparam int HALF_BITS = sata_phy_pkg::HALF_BYTES * 8;
    localparam int WORD_BITS = sata_phy_pkg::DATA_BYTES * 8;
    localparam int HALF      = sata_phy_pkg::HALF_BYTES;
    localparam int FULL      = sata_phy_pkg::DATA_BYTES;

    logic twobytes_shift;

    // exchange upper and lower half of a flag lane
    function automatic sata_phy_pkg::flags_t swap_flags(input sata_phy_pkg::flags_t f);
        return {f[HALF-1:0], f[FULL-1:HALF]};
    endfunction

    // comma in byte 2 means the word boundary sits mid-word
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            twobytes_shift <= 1'b0;
        end else if (rst) begin
            twobytes_shift <= 1'b0;
        end else if (rxchariscomma_gtx[HALF]) begin
            twobytes_shift <= 1'b1;
        end else if (rxchariscomma_gtx[0]) begin
            twobytes_shift <= 1'b0;
        end
    end

    // no register in the data path
    assign rxdata = twobytes_shift ? {rxdata_gtx[HALF_BITS-1:0],
                                      rxdata_gtx[WORD_BITS-1:HALF_BITS]}
                                   : rxdata_gtx;

    assign rxcharisk    = twobytes_shift ? swap_flags(rxcharisk_gtx) : rxcharisk_gtx;
    assign rxdisperr    = twobytes_shift ? swap_flags(rxdisperr_gtx) : rxdisperr_gtx;
    assign rxnotintable = twobytes_shift ? swap_flags(rxnotintable_gtx) : rxnotintable_gtx;

endmodule

// File: src/sata_phy_core.sv
`timescale 1ns/1ps

module sata_phy_core (
    input  logic                 clk,
    input  logic                 extrst,
    // transceiver status
    input  logic                 cplllock,
    input  logic                 usrpll_locked,
    input  logic                 rxresetdone,
    input  logic                 txresetdone,
    // from the oob controller
    input  logic                 txpcsreset_req,
    input  logic                 link_up,
    input  sata_phy_pkg::word_t  txdata_oob,
    input  sata_phy_pkg::flags_t txcharisk_oob,
    // from the link layer
    input  sata_phy_pkg::word_t  ll_data_in,
    input  sata_phy_pkg::flags_t ll_charisk_in,
    // rx lanes of the transceiver
    input  sata_phy_pkg::word_t  rxdata_gtx,
    input  sata_phy_pkg::flags_t rxcharisk_gtx,
    input  sata_phy_pkg::flags_t rxchariscomma_gtx,
    input  sata_phy_pkg::flags_t rxdisperr_gtx,
    input  sata_phy_pkg::flags_t rxnotintable_gtx,
    // reset and ready state
    output logic                 rst,
    output logic                 gtx_ready,
    output logic                 gtxreset,
    output logic                 rxuserrdy,
    output logic                 txuserrdy,
    output logic                 txpcsreset,
    output logic                 recal_tx_done,
    // tx lanes to the transceiver
    output sata_phy_pkg::word_t  txdata,
    output sata_phy_pkg::flags_t txcharisk,
    // to the link layer
    output sata_phy_pkg::word_t  ll_data_out,
    output sata_phy_pkg::flags_t ll_charisk_out,
    output sata_phy_pkg::flags_t ll_err_out
);

    // aligned rx lanes
    sata_phy_pkg::word_t  rxdata;
    sata_phy_pkg::flags_t rxcharisk;
    sata_phy_pkg::flags_t rxdisperr;
    sata_phy_pkg::flags_t rxnotintable;

    phy_reset_seq phy_reset_seq_i (
        .clk            (clk),
        .extrst         (extrst),
        .cplllock       (cplllock),
        .usrpll_locked  (usrpll_locked),
        .rxresetdone    (rxresetdone),
        .txresetdone    (txresetdone),
        .txpcsreset_req (txpcsreset_req),
        .gtxreset       (gtxreset),
        .rxuserrdy      (rxuserrdy),
        .txuserrdy      (txuserrdy),
        .gtx_ready      (gtx_ready),
        .rst            (rst),
        .txpcsreset     (txpcsreset),
        .recal_tx_done  (recal_tx_done)
    );

    rx_word_align rx_word_align_i (
        .clk               (clk),
        .extrst            (extrst),
        .rst               (rst),
        .rxdata_gtx        (rxdata_gtx),
        .rxcharisk_gtx     (rxcharisk_gtx),
        .rxchariscomma_gtx (rxchariscomma_gtx),
        .rxdisperr_gtx     (rxdisperr_gtx),
        .rxnotintable_gtx  (rxnotintable_gtx),
        .rxdata            (rxdata),
        .rxcharisk         (rxcharisk),
        .rxdisperr         (rxdisperr),
        .rxnotintable      (rxnotintable)
    );

    link_port link_port_i (
        .clk            (clk),
        .extrst         (extrst),
        .rst            (rst),
        .link_up        (link_up),
        .ll_data_in     (ll_data_in),
        .ll_charisk_in  (ll_charisk_in),
        .txdata_oob     (txdata_oob),
        .txcharisk_oob  (txcharisk_oob),
        .rxdata         (rxdata),
        .rxcharisk      (rxcharisk),
        .rxdisperr      (rxdisperr),
        .rxnotintable   (rxnotintable),
        .txdata         (txdata),
        .txcharisk      (txcharisk),
        .ll_data_out    (ll_data_out),
        .ll_charisk_out (ll_charisk_out),
        .ll_err_out     (ll_err_out)
    );

endmodule

// File: src/sata_phy_pkg.sv
package sata_phy_pkg;

    // lane geometry
    localparam int DATA_BYTES = 4;
    localparam int HALF_BYTES = DATA_BYTES / 2;

    // one lane word and its per-byte flags
    typedef logic [DATA_BYTES*8-1:0] word_t;
    typedef logic [DATA_BYTES-1:0]   flags_t;

    // tx side, PMA reset window in clk cycles
    localparam logic [2:0] TXPMARESET_TIME = 3'd1;

    // rx side, individual reset windows of the transceiver
    localparam logic [6:0] RXPMARESET_TIME     = 7'd17;
    localparam logic [6:0] RXCDRPHRESET_TIME   = 7'd1;
    localparam logic [6:0] RXCDRFREQRESET_TIME = 7'd1;
    localparam logic [6:0] RXDFELPMRESET_TIME  = 7'd15;
    localparam logic [6:0] RXISCANRESET_TIME   = 7'd1;

    // rx user-ready waits for the whole eye reset chain
    localparam logic [6:0] RXEYERESET_TIME = RXPMARESET_TIME
                                           + RXCDRPHRESET_TIME
                                           + RXCDRFREQRESET_TIME
                                           + RXDFELPMRESET_TIME
                                           + RXISCANRESET_TIME;

    // internal reset timer, pulse covers counts 1 .. limit-1
    localparam logic [7:0] RST_TIMER_LIMIT = 8'd8;

    // partial tx pcs reset after the oob sequence
    localparam logic [3:0] TXPCSRESET_CYCLES = 4'd8;

endpackage
